// File: source/mc_wh_pkg.sv
/*
  Manycore to wormhole adapter definitions
  Flit and header widths, manycore and wormhole packet layouts,
  flit counts per network and network indices
*/

package mc_wh_pkg;

  // Wormhole link widths
  localparam int flit_width = 16;
  localparam int cord_width = 4;
  localparam int len_width  = 2;

  // Dual-clock FIFO depth is 2**fifo_lg_depth flits
  localparam int fifo_lg_depth = 3;

  // Network indices on the mesh ports
  localparam int rev_net = 0;
  localparam int fwd_net = 1;

  typedef logic [flit_width-1:0] flit_t;

  typedef struct packed {
    logic [cord_width-1:0] cord;
    logic [len_width-1:0]  len;
  } wh_hdr_t;

  // Forward request from the manycore
  typedef struct packed {
    logic [1:0]  op;
    logic [15:0] addr;
    logic [15:0] data;
    logic [1:0]  src_y;
    logic [1:0]  src_x;
    logic [1:0]  dst_y;
    logic [1:0]  dst_x;
  } mc_fwd_packet_t;

  // Return packet to the requester
  typedef struct packed {
    logic [1:0]  pkt_type;
    logic [3:0]  load_id;
    logic [15:0] data;
    logic [1:0]  y_cord;
    logic [1:0]  x_cord;
  } mc_rev_packet_t;

  // Header in the low bits so that flit 0 carries it
  typedef struct packed {
    mc_fwd_packet_t payload;
    wh_hdr_t        hdr;
  } wh_fwd_packet_t;

  typedef struct packed {
    mc_rev_packet_t payload;
    wh_hdr_t        hdr;
  } wh_rev_packet_t;

  localparam int fwd_flits = ($bits(wh_fwd_packet_t) + flit_width - 1) / flit_width;
  localparam int rev_flits = ($bits(wh_rev_packet_t) + flit_width - 1) / flit_width;

endpackage

// File: source/wh_async_fifo.sv
/*
  Dual-clock flit FIFO, depth 8
  Gray-coded pointers cross through two flops each way
*/

`timescale 1ns/1ps

module wh_async_fifo
  (
    input  logic              w_clk_i,
    input  logic              w_enq_i,
    input  mc_wh_pkg::flit_t  w_data_i,
    output logic              w_full_o,

    input  logic              r_clk_i,
    input  logic              r_deq_i,
    output mc_wh_pkg::flit_t  r_data_o,
    output logic              r_valid_o,

    input  logic              rst_n_i
  );

  // One extra pointer bit tells full from empty
  logic [mc_wh_pkg::fifo_lg_depth:0] w_bin_r, w_gray_r, w_bin_next;
  logic [mc_wh_pkg::fifo_lg_depth:0] r_bin_r, r_gray_r, r_bin_next;
  logic [mc_wh_pkg::fifo_lg_depth:0] r_gray_sync1_r, r_gray_sync2_r;
  logic [mc_wh_pkg::fifo_lg_depth:0] w_gray_sync1_r, w_gray_sync2_r;
  logic                              w_push, r_pop;

  mc_wh_pkg::flit_t mem_r [(1 << mc_wh_pkg::fifo_lg_depth)];

  assign w_push     = w_enq_i & ~w_full_o;
  assign r_pop      = r_deq_i & r_valid_o;
  assign w_bin_next = w_bin_r + w_push;
  assign r_bin_next = r_bin_r + r_pop;

  // Write domain
  always_ff @(posedge w_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      w_bin_r        <= '0;
      w_gray_r       <= '0;
      r_gray_sync1_r <= '0;
      r_gray_sync2_r <= '0;
    end
    else
    begin
      w_bin_r        <= w_bin_next;
      w_gray_r       <= w_bin_next ^ (w_bin_next >> 1);
      r_gray_sync1_r <= r_gray_r;
      r_gray_sync2_r <= r_gray_sync1_r;
    end
  end

  always_ff @(posedge w_clk_i)
  begin
    if (w_push)
      mem_r[w_bin_r[mc_wh_pkg::fifo_lg_depth-1:0]] <= w_data_i;
  end

  // Full when the read pointer is a whole lap behind
  assign w_full_o = (w_gray_r == {~r_gray_sync2_r[mc_wh_pkg::fifo_lg_depth -: 2],
                                  r_gray_sync2_r[mc_wh_pkg::fifo_lg_depth-2:0]});

  // Read domain
  always_ff @(posedge r_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      r_bin_r        <= '0;
      r_gray_r       <= '0;
      w_gray_sync1_r <= '0;
      w_gray_sync2_r <= '0;
    end
    else
    begin
      r_bin_r        <= r_bin_next;
      r_gray_r       <= r_bin_next ^ (r_bin_next >> 1);
      w_gray_sync1_r <= w_gray_r;
      w_gray_sync2_r <= w_gray_sync1_r;
    end
  end

  assign r_valid_o = (r_gray_r != w_gray_sync2_r);
  assign r_data_o  = mem_r[r_bin_r[mc_wh_pkg::fifo_lg_depth-1:0]];

endmodule

// File: source/wh_piso.sv
/*
  Parallel-in serial-out converter
  Latches one packet and hands it out as flits, lowest flit first
*/

`timescale 1ns/1ps

module wh_piso
  #(
    parameter type packet_t = logic [15:0],
    parameter int  els      = ($bits(packet_t) + mc_wh_pkg::flit_width - 1)
                              / mc_wh_pkg::flit_width
  )
  (
    input  logic             manycore_clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    input  packet_t          data_i,
    output logic             ready_o,
    output logic             valid_o,
    output mc_wh_pkg::flit_t data_o,
    input  logic             yumi_i
  );

  logic [els*mc_wh_pkg::flit_width-1:0] pad_w;
  mc_wh_pkg::flit_t [els-1:0]           buf_r;
  logic [$clog2(els+1)-1:0]             idx_r;
  logic                                 busy_r;

  // Zero fill above the packet up to a whole number of flits
  always_comb
  begin
    pad_w = '0;
    pad_w[$bits(packet_t)-1:0] = data_i;
  end

  always_ff @(posedge manycore_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end
    else if (!busy_r)
    begin
      if (valid_i)
      begin
        busy_r <= 1'b1;
        idx_r  <= '0;
      end
    end
    else if (yumi_i)
    begin
      // Free after the last flit is taken
      if (int'(idx_r) == els - 1)
        busy_r <= 1'b0;
      else
        idx_r <= idx_r + 1'b1;
    end
  end

  always_ff @(posedge manycore_clk_i)
  begin
    if (valid_i && ready_o)
      buf_r <= pad_w;
  end

  assign ready_o = ~busy_r;
  assign valid_o = busy_r;
  assign data_o  = buf_r[idx_r];

endmodule

// File: source/wh_sipo.sv
/*
  Serial-in parallel-out collector
  Gathers flits into one packet and holds it until yumi
*/

`timescale 1ns/1ps

module wh_sipo
  #(
    parameter type packet_t = logic [15:0],
    parameter int  els      = ($bits(packet_t) + mc_wh_pkg::flit_width - 1)
                              / mc_wh_pkg::flit_width
  )
  (
    input  logic             manycore_clk_i,
    input  logic             rst_n_i,
    input  logic             v_i,
    input  mc_wh_pkg::flit_t data_i,
    output logic             ready_o,
    output logic             v_o,
    output packet_t          data_o,
    input  logic             yumi_i
  );

  mc_wh_pkg::flit_t [els-1:0]           slot_r;
  logic [els*mc_wh_pkg::flit_width-1:0] flat_w;
  logic [$clog2(els+1)-1:0]             cnt_r;
  logic                                 full_r;

  always_ff @(posedge manycore_clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_r  <= '0;
      full_r <= 1'b0;
    end
    else if (full_r)
    begin
      // Packet leaves, ready again next cycle
      if (yumi_i)
        full_r <= 1'b0;
    end
    else if (v_i)
    begin
      if (int'(cnt_r) == els - 1)
      begin
        cnt_r  <= '0;
        full_r <= 1'b1;
      end
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge manycore_clk_i)
  begin
    if (v_i && ready_o)
      slot_r[cnt_r] <= data_i;
  end

  assign flat_w  = slot_r;
  assign ready_o = ~full_r;
  assign v_o     = full_r;

  // Drop the padding above the packet
  assign data_o  = flat_w[$bits(packet_t)-1:0];

endmodule

// File: source/mc_link_async_to_wormhole.sv
/*
  Manycore link to wormhole mesh adapter
  Adds and strips wormhole headers, serializes packets into flits
  and crosses both networks between the manycore and mesh clocks
*/

`timescale 1ns/1ps

module mc_link_async_to_wormhole
  (
    input  logic                              manycore_clk_i,
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic [mc_wh_pkg::cord_width-1:0]  dest_cord_i,

    // Manycore outbound
    input  logic                              mc_fwd_v_i,
    input  mc_wh_pkg::mc_fwd_packet_t         mc_fwd_data_i,
    output logic                              mc_fwd_ready_o,
    input  logic                              mc_rev_v_i,
    input  mc_wh_pkg::mc_rev_packet_t         mc_rev_data_i,
    output logic                              mc_rev_ready_o,

    // Manycore inbound
    output logic                              mc_fwd_v_o,
    output mc_wh_pkg::mc_fwd_packet_t         mc_fwd_data_o,
    input  logic                              mc_fwd_ready_i,
    output logic                              mc_rev_v_o,
    output mc_wh_pkg::mc_rev_packet_t         mc_rev_data_o,
    input  logic                              mc_rev_ready_i,

    // Mesh links, indexed by network
    input  logic [1:0]                        wh_v_i,
    input  mc_wh_pkg::flit_t [1:0]            wh_data_i,
    output logic [1:0]                        wh_ready_o,
    output logic [1:0]                        wh_v_o,
    output mc_wh_pkg::flit_t [1:0]            wh_data_o,
    input  logic [1:0]                        wh_ready_i
  );

  mc_wh_pkg::wh_fwd_packet_t fwd_out_pkt, fwd_in_pkt;
  mc_wh_pkg::wh_rev_packet_t rev_out_pkt, rev_in_pkt;

  // Manycore side flit streams
  logic [1:0]             piso_v, piso_yumi, out_full;
  mc_wh_pkg::flit_t [1:0] piso_data, in_data;
  logic [1:0]             in_v, sipo_ready, in_deq;

  // Mesh side
  logic [1:0]             wh_in_full;

  // Header goes in front of each outbound packet
  always_comb
  begin
    fwd_out_pkt.payload  = mc_fwd_data_i;
    fwd_out_pkt.hdr.cord = dest_cord_i;
    fwd_out_pkt.hdr.len  = mc_wh_pkg::len_width'(mc_wh_pkg::fwd_flits - 1);
    rev_out_pkt.payload  = mc_rev_data_i;
    rev_out_pkt.hdr.cord = dest_cord_i;
    rev_out_pkt.hdr.len  = mc_wh_pkg::len_width'(mc_wh_pkg::rev_flits - 1);
  end

  assign mc_fwd_data_o = fwd_in_pkt.payload;
  assign mc_rev_data_o = rev_in_pkt.payload;

  // A flit leaves the serializer whenever the FIFO has room
  assign piso_yumi  = piso_v & ~out_full;
  assign in_deq     = in_v & sipo_ready;
  assign wh_ready_o = ~wh_in_full;

  wh_piso #(.packet_t(mc_wh_pkg::wh_fwd_packet_t), .els(mc_wh_pkg::fwd_flits)) fwd_piso
    (.manycore_clk_i(manycore_clk_i), .rst_n_i(rst_n_i),
     .valid_i(mc_fwd_v_i), .data_i(fwd_out_pkt), .ready_o(mc_fwd_ready_o),
     .valid_o(piso_v[mc_wh_pkg::fwd_net]), .data_o(piso_data[mc_wh_pkg::fwd_net]),
     .yumi_i(piso_yumi[mc_wh_pkg::fwd_net]));

  wh_piso #(.packet_t(mc_wh_pkg::wh_rev_packet_t), .els(mc_wh_pkg::rev_flits)) rev_piso
    (.manycore_clk_i(manycore_clk_i), .rst_n_i(rst_n_i),
     .valid_i(mc_rev_v_i), .data_i(rev_out_pkt), .ready_o(mc_rev_ready_o),
     .valid_o(piso_v[mc_wh_pkg::rev_net]), .data_o(piso_data[mc_wh_pkg::rev_net]),
     .yumi_i(piso_yumi[mc_wh_pkg::rev_net]));

  // Consumer ready doubles as the collector's yumi
  wh_sipo #(.packet_t(mc_wh_pkg::wh_fwd_packet_t), .els(mc_wh_pkg::fwd_flits)) fwd_sipo
    (.manycore_clk_i(manycore_clk_i), .rst_n_i(rst_n_i),
     .v_i(in_v[mc_wh_pkg::fwd_net]), .data_i(in_data[mc_wh_pkg::fwd_net]),
     .ready_o(sipo_ready[mc_wh_pkg::fwd_net]), .v_o(mc_fwd_v_o), .data_o(fwd_in_pkt),
     .yumi_i(mc_fwd_v_o & mc_fwd_ready_i));

  wh_sipo #(.packet_t(mc_wh_pkg::wh_rev_packet_t), .els(mc_wh_pkg::rev_flits)) rev_sipo
    (.manycore_clk_i(manycore_clk_i), .rst_n_i(rst_n_i),
     .v_i(in_v[mc_wh_pkg::rev_net]), .data_i(in_data[mc_wh_pkg::rev_net]),
     .ready_o(sipo_ready[mc_wh_pkg::rev_net]), .v_o(mc_rev_v_o), .data_o(rev_in_pkt),
     .yumi_i(mc_rev_v_o & mc_rev_ready_i));

  for (genvar n = 0; n < 2; n++)
  begin : g_net
    // Manycore clock to mesh clock
    wh_async_fifo mc_to_wh
      (.w_clk_i(manycore_clk_i), .w_enq_i(piso_yumi[n]), .w_data_i(piso_data[n]),
       .w_full_o(out_full[n]),
       .r_clk_i(clk_i), .r_deq_i(wh_v_o[n] & wh_ready_i[n]), .r_data_o(wh_data_o[n]),
       .r_valid_o(wh_v_o[n]),
       .rst_n_i(rst_n_i));

    // Mesh clock to manycore clock
    wh_async_fifo wh_to_mc
      (.w_clk_i(clk_i), .w_enq_i(wh_v_i[n] & wh_ready_o[n]), .w_data_i(wh_data_i[n]),
       .w_full_o(wh_in_full[n]),
       .r_clk_i(manycore_clk_i), .r_deq_i(in_deq[n]), .r_data_o(in_data[n]),
       .r_valid_o(in_v[n]),
       .rst_n_i(rst_n_i));
  end

endmodule

// File: dv/mc_link_async_to_wormhole_sva.sv
/*
  Handshake assertions for the manycore to wormhole adapter
  Bound into the top level from the testbench
*/

`timescale 1ns/1ps

module mc_link_async_to_wormhole_sva
  (
    input logic                      manycore_clk_i,
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      mc_fwd_v_o,
    input mc_wh_pkg::mc_fwd_packet_t mc_fwd_data_o,
    input logic                      mc_fwd_ready_i,
    input logic                      mc_rev_v_o,
    input mc_wh_pkg::mc_rev_packet_t mc_rev_data_o,
    input logic                      mc_rev_ready_i,
    input logic [1:0]                wh_v_i,
    input logic [1:0]                wh_ready_o,
    input logic [1:0]                wh_v_o,
    input mc_wh_pkg::flit_t [1:0]    wh_data_o,
    input logic [1:0]                wh_ready_i
  );

  // Reassembled packets wait for the consumer
  fwd_hold_a: assert property (@(posedge manycore_clk_i) disable iff (!rst_n_i)
    mc_fwd_v_o && !mc_fwd_ready_i |=> mc_fwd_v_o && $stable(mc_fwd_data_o))
    else $error("mc_fwd_v_o dropped or its data changed before ready");

  rev_hold_a: assert property (@(posedge manycore_clk_i) disable iff (!rst_n_i)
    mc_rev_v_o && !mc_rev_ready_i |=> mc_rev_v_o && $stable(mc_rev_data_o))
    else $error("mc_rev_v_o dropped or its data changed before ready");

  for (genvar n = 0; n < 2; n++)
  begin : g_net
    wh_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wh_v_o[n] && !wh_ready_i[n] |=> wh_v_o[n] && $stable(wh_data_o[n]))
      else $error("wh_v_o[%0d] dropped or its flit changed before ready", n);

    // Inbound FIFO fills only from flits that were offered
    ready_fall_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $fell(wh_ready_o[n]) |-> $past(wh_v_i[n]))
      else $error("wh_ready_o[%0d] fell with no flit offered", n);
  end

  reset_mesh_a: assert property (@(posedge clk_i) !rst_n_i |-> wh_v_o == 2'b00)
    else $error("wh_v_o high during reset");

  reset_mc_a: assert property (@(posedge manycore_clk_i)
    !rst_n_i |-> !mc_fwd_v_o && !mc_rev_v_o)
    else $error("Manycore valid high during reset");

endmodule

// File: dv/tb_mc_link_async_to_wormhole.sv
/*
  Testbench for the manycore to wormhole adapter
  Directed tests with queue models on both clock domains
*/

`timescale 1ns/1ps

module tb_mc_link_async_to_wormhole;

  localparam int test_count = 5;
  // Longest test, in manycore clock cycles
  localparam int test_bound = 400;

  logic                             manycore_clk_i, clk_i, rst_n_i;
  logic [mc_wh_pkg::cord_width-1:0] dest_cord_i;
  logic                             mc_fwd_v_i, mc_fwd_ready_o, mc_rev_v_i, mc_rev_ready_o;
  mc_wh_pkg::mc_fwd_packet_t        mc_fwd_data_i, mc_fwd_data_o;
  mc_wh_pkg::mc_rev_packet_t        mc_rev_data_i, mc_rev_data_o;
  logic                             mc_fwd_v_o, mc_fwd_ready_i, mc_rev_v_o, mc_rev_ready_i;
  logic [1:0]                       wh_v_i, wh_ready_o, wh_v_o, wh_ready_i;
  mc_wh_pkg::flit_t [1:0]           wh_data_i, wh_data_o;

  // Packets still to send and responses still expected
  mc_wh_pkg::mc_fwd_packet_t fwd_pkt_q[$], exp_fwd_q[$];
  mc_wh_pkg::mc_rev_packet_t rev_pkt_q[$], exp_rev_q[$];
  mc_wh_pkg::flit_t          exp_flit_q[2][$], wh_send_q[2][$];

  logic [31:0]  lfsr_state;
  logic [255:0] mesh_gaps, mc_gaps;
  logic [1:0]   mesh_hold;
  logic         rev_hold, gaps_on;
  int           err_value, err_other;
  string        test_name;

  mc_link_async_to_wormhole dut_i (.*);

  bind mc_link_async_to_wormhole mc_link_async_to_wormhole_sva sva_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial
  begin
    manycore_clk_i = 1'b0;
    forever #28 manycore_clk_i = ~manycore_clk_i;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic mc_wh_pkg::mc_fwd_packet_t rand_fwd();
    logic [41:0] v;
    v[41:32] = 10'(rand_bits(10));
    v[31:0]  = rand_bits(32);
    return v;
  endfunction

  function automatic mc_wh_pkg::mc_rev_packet_t rand_rev();
    logic [25:0] v;
    v = 26'(rand_bits(26));
    return v;
  endfunction

  function automatic logic stall(input logic [255:0] pat, input int cyc, input int d);
    return gaps_on && pat[(cyc * 4 + d) % 256];
  endfunction

  function automatic logic traffic_idle();
    return fwd_pkt_q.size() == 0 && rev_pkt_q.size() == 0 && exp_fwd_q.size() == 0
           && exp_rev_q.size() == 0 && exp_flit_q[0].size() == 0
           && exp_flit_q[1].size() == 0 && wh_send_q[0].size() == 0
           && wh_send_q[1].size() == 0;
  endfunction

  task automatic other_error(input string msg);
    err_other++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic check_flit(input mc_wh_pkg::flit_t exp, input mc_wh_pkg::flit_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("** Error [%s] flit: expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_fwd(input mc_wh_pkg::mc_fwd_packet_t exp,
                           input mc_wh_pkg::mc_fwd_packet_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("** Error [%s] fwd packet: expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_rev(input mc_wh_pkg::mc_rev_packet_t exp,
                           input mc_wh_pkg::mc_rev_packet_t act);
    if (act !== exp)
    begin
      err_value++;
      $display("** Error [%s] rev packet: expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_status(input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      err_value++;
      $display("** Error [%s] valids and readies: expected %b, actual %b",
               test_name, exp, act);
    end
  endtask

  // Flit i carries bits 16*i+15 to 16*i of the wormhole packet
  task automatic queue_flits(input logic inject, input int net, input logic [47:0] w,
                             input int count);
    for (int i = 0; i < count; i++)
    begin
      if (inject)
        wh_send_q[net].push_back(w[16*i +: 16]);
      else
        exp_flit_q[net].push_back(w[16*i +: 16]);
    end
  endtask

  // Inbound header cord is arbitrary and len is the flit count minus one
  task automatic send_fwd_in(input mc_wh_pkg::mc_fwd_packet_t p);
    queue_flits(1'b1, mc_wh_pkg::fwd_net, {p, 4'(rand_bits(4)), 2'd2}, 3);
    exp_fwd_q.push_back(p);
  endtask

  task automatic send_rev_in(input mc_wh_pkg::mc_rev_packet_t p);
    queue_flits(1'b1, mc_wh_pkg::rev_net, 48'({p, 4'(rand_bits(4)), 2'd1}), 2);
    exp_rev_q.push_back(p);
  endtask

  // Manycore side drivers and monitors
  initial
  begin
    int cyc;
    cyc = 0;
    forever
    begin
      @(negedge manycore_clk_i);
      cyc++;
      if (rst_n_i)
      begin
        mc_fwd_v_i = 1'b0;
        if (fwd_pkt_q.size() > 0 && mc_fwd_ready_o && !stall(mc_gaps, cyc, 0))
        begin
          mc_fwd_v_i    = 1'b1;
          mc_fwd_data_i = fwd_pkt_q.pop_front();
          queue_flits(1'b0, mc_wh_pkg::fwd_net, {mc_fwd_data_i, dest_cord_i, 2'd2}, 3);
        end
        mc_rev_v_i = 1'b0;
        if (rev_pkt_q.size() > 0 && mc_rev_ready_o && !stall(mc_gaps, cyc, 1))
        begin
          mc_rev_v_i    = 1'b1;
          mc_rev_data_i = rev_pkt_q.pop_front();
          queue_flits(1'b0, mc_wh_pkg::rev_net, 48'({mc_rev_data_i, dest_cord_i, 2'd1}), 2);
        end
        mc_fwd_ready_i = !stall(mc_gaps, cyc, 2);
        if (mc_fwd_v_o && mc_fwd_ready_i)
        begin
          if (exp_fwd_q.size() == 0)
            other_error("mc_fwd_v_o delivered a packet that was never sent");
          else
            check_fwd(exp_fwd_q.pop_front(), mc_fwd_data_o);
        end
        mc_rev_ready_i = !rev_hold && !stall(mc_gaps, cyc, 3);
        if (mc_rev_v_o && mc_rev_ready_i)
        begin
          if (exp_rev_q.size() == 0)
            other_error("mc_rev_v_o delivered a packet that was never sent");
          else
            check_rev(exp_rev_q.pop_front(), mc_rev_data_o);
        end
      end
    end
  end

  // Mesh side drivers and monitors
  initial
  begin
    int cyc;
    cyc = 0;
    forever
    begin
      @(negedge clk_i);
      cyc++;
      if (rst_n_i)
      begin
        for (int n = 0; n < 2; n++)
        begin
          wh_ready_i[n] = !mesh_hold[n] && !stall(mesh_gaps, cyc, n);
          if (wh_v_o[n] && wh_ready_i[n])
          begin
            if (exp_flit_q[n].size() == 0)
              other_error($sformatf("unexpected flit on mesh net %0d", n));
            else
              check_flit(exp_flit_q[n].pop_front(), wh_data_o[n]);
          end
          wh_v_i[n] = 1'b0;
          if (wh_send_q[n].size() > 0 && wh_ready_o[n] && !stall(mesh_gaps, cyc, n + 2))
          begin
            wh_v_i[n]    = 1'b1;
            wh_data_i[n] = wh_send_q[n].pop_front();
          end
        end
      end
    end
  end

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (!traffic_idle() && cycles < test_bound)
    begin
      @(negedge manycore_clk_i);
      cycles++;
    end
    if (!traffic_idle())
      other_error($sformatf("traffic still pending after %0d manycore cycles", cycles));
    // Leave time for any stray output to show up
    repeat (20) @(negedge manycore_clk_i);
  endtask

  task automatic test_fwd_out();
    test_name = "fwd_out";
    @(negedge manycore_clk_i);
    dest_cord_i = 4'h6;
    fwd_pkt_q.push_back(rand_fwd());
    wait_drained();
  endtask

  task automatic test_rev_out();
    test_name = "rev_out";
    @(negedge manycore_clk_i);
    dest_cord_i = 4'h9;
    rev_pkt_q.push_back(rand_rev());
    wait_drained();
  endtask

  task automatic test_packets_in();
    test_name = "packets_in";
    @(negedge manycore_clk_i);
    for (int i = 0; i < 2; i++)
    begin
      send_fwd_in(rand_fwd());
      send_rev_in(rand_rev());
    end
    wait_drained();
  endtask

  task automatic test_backpressure();
    test_name = "backpressure";
    @(negedge manycore_clk_i);
    mesh_hold[mc_wh_pkg::fwd_net] = 1'b1;
    repeat (6) fwd_pkt_q.push_back(rand_fwd());
    repeat (60) @(negedge manycore_clk_i);
    if (mc_fwd_ready_o !== 1'b0 || fwd_pkt_q.size() == 0)
      other_error("mc_fwd_ready_o stayed high with the mesh stalled");
    mesh_hold[mc_wh_pkg::fwd_net] = 1'b0;
    wait_drained();
    rev_hold = 1'b1;
    repeat (6) send_rev_in(rand_rev());
    repeat (60) @(negedge manycore_clk_i);
    @(negedge clk_i);
    if (wh_ready_o[mc_wh_pkg::rev_net] !== 1'b0 || wh_send_q[mc_wh_pkg::rev_net].size() == 0)
      other_error("wh_ready_o on the rev net stayed high with the manycore stalled");
    @(negedge manycore_clk_i);
    rev_hold = 1'b0;
    wait_drained();
  endtask

  task automatic test_concurrent();
    test_name = "concurrent";
    for (int i = 0; i < 8; i++)
    begin
      mesh_gaps[32*i +: 32] = rand_bits(32);
      mc_gaps[32*i +: 32]   = rand_bits(32);
    end
    @(negedge manycore_clk_i);
    gaps_on = 1'b1;
    for (int i = 0; i < 16; i++)
    begin
      fwd_pkt_q.push_back(rand_fwd());
      rev_pkt_q.push_back(rand_rev());
      send_fwd_in(rand_fwd());
      send_rev_in(rand_rev());
    end
    wait_drained();
    gaps_on = 1'b0;
  endtask

  initial
  begin
    lfsr_state     = 32'h8223_2de9;
    rst_n_i        = 1'b0;
    dest_cord_i    = '0;
    mc_fwd_v_i     = 1'b0;
    mc_fwd_data_i  = '0;
    mc_rev_v_i     = 1'b0;
    mc_rev_data_i  = '0;
    mc_fwd_ready_i = 1'b0;
    mc_rev_ready_i = 1'b0;
    wh_v_i         = '0;
    wh_data_i      = '0;
    wh_ready_i     = '0;
    mesh_hold      = '0;
    rev_hold       = 1'b0;
    gaps_on        = 1'b0;
    mesh_gaps      = '0;
    mc_gaps        = '0;
    err_value      = 0;
    err_other      = 0;
    test_name      = "reset";
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge manycore_clk_i);
    // Valids low and readies high
    check_status(8'b0000_1111, {mc_fwd_v_o, mc_rev_v_o, wh_v_o,
                                mc_fwd_ready_o, mc_rev_ready_o, wh_ready_o});
    test_fwd_out();
    test_rev_out();
    test_packets_in();
    test_backpressure();
    test_concurrent();
    $display("Error counts: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    repeat (test_count * test_bound) @(posedge manycore_clk_i);
    $display("Watchdog expired after %0d manycore cycles in %s",
             test_count * test_bound, test_name);
    $display("Test failed");
    $finish;
  end

endmodule

// File: list.f
source/mc_wh_pkg.sv
source/wh_async_fifo.sv
source/wh_piso.sv
source/wh_sipo.sv
source/mc_link_async_to_wormhole.sv
dv/mc_link_async_to_wormhole_sva.sv
dv/tb_mc_link_async_to_wormhole.sv

// File: run.sh
#!/bin/sh
# Build and run the adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mc_link_async_to_wormhole \
  -f list.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
